/* common/dbg_defines.svh */
`ifndef DBG_DEFINES_SVH
`define DBG_DEFINES_SVH

//////////////////////////////////////////////////
// stream widths
//////////////////////////////////////////////////

`define DBG_DATA_WIDTH 64
`define DBG_DEST_WIDTH 16

//////////////////////////////////////////////////
// command word layout
//////////////////////////////////////////////////

`define DBG_CMD_WIDTH 32
// opcode sits in the low bits
`define DBG_OP_WIDTH 4
`define DBG_CHAN_BIT 4
// inject payload, 16 bits
`define DBG_INJ_LSB 13
`define DBG_INJ_MSB 28

`endif

/* common/dbg_pkg.sv */
`include "dbg_defines.svh"

package dbg_pkg;

    //////////////////////////////////////////////////
    // command decode
    //////////////////////////////////////////////////

    typedef enum logic [`DBG_OP_WIDTH-1:0] {
        OP_NOP     = 4'd0,
        OP_PAUSE   = 4'd1,
        OP_UNPAUSE = 4'd2,
        OP_DROP    = 4'd3,
        OP_UNDROP  = 4'd4,
        OP_LOG     = 4'd5,
        OP_UNLOG   = 4'd6,
        OP_INJECT  = 4'd7
    } dbg_op_e;

    // also used as index into the per-channel registers
    typedef enum logic {
        CH_RDATA = 1'b0,
        CH_WDATA = 1'b1
    } dbg_chan_e;

    //////////////////////////////////////////////////
    // beat payloads
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [`DBG_DATA_WIDTH-1:0] data;
        logic [`DBG_DEST_WIDTH-1:0] dest;
    } rdata_beat_t;

    typedef struct packed {
        logic [`DBG_DATA_WIDTH-1:0] data;
    } wdata_beat_t;

endpackage

/* governor/stream_governor.sv */
`timescale 1ns/100ps
`include "dbg_defines.svh"

module stream_governor #(
    parameter type beat_t = logic [`DBG_DATA_WIDTH-1:0]
) (
    input  logic  clk,
    input  logic  rst,

    // upstream
    input  beat_t in_beat_i,
    input  logic  in_valid_i,
    output logic  in_ready_o,

    // downstream
    output beat_t out_beat_o,
    output logic  out_valid_o,
    input  logic  out_ready_i,

    // inject from the controller
    input  beat_t inj_beat_i,
    input  logic  inj_valid_i,
    output logic  inj_ready_o,

    // log tap
    output beat_t log_beat_o,
    output logic  log_valid_o,
    input  logic  log_ready_i,

    input  logic  pause_i,
    input  logic  drop_i,
    input  logic  log_en_i
);

    beat_t out_q;
    logic  out_valid_q;
    logic  reg_free;
    logic  in_open;
    logic  in_take;
    logic  in_pass;
    logic  inj_take;

    // register empty, or its beat leaves this cycle
    assign reg_free = ~out_valid_q | out_ready_i;

    // inject wins, then pause, then drop bypasses the register
    assign in_open  = ~inj_valid_i & ~pause_i & (drop_i | reg_free);
    assign in_ready_o = in_open & (~log_en_i | log_ready_i);

    assign in_take  = in_valid_i & in_ready_o;
    assign in_pass  = in_take & ~drop_i;

    assign inj_ready_o = reg_free;
    assign inj_take    = inj_valid_i & reg_free;

    //////////////////////////////////////////////////
    // log tap
    //////////////////////////////////////////////////

    // offered whenever the input would otherwise be taken
    assign log_valid_o = in_valid_i & log_en_i & in_open;
    assign log_beat_o  = in_beat_i;

    //////////////////////////////////////////////////
    // one-entry output register
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_q <= 1'b0;
        end else if (inj_take | in_pass) begin
            out_valid_q <= 1'b1;
        end else if (out_ready_i) begin
            out_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (inj_take) begin
            out_q <= inj_beat_i;
        end else if (in_pass) begin
            out_q <= in_beat_i;
        end
    end

    assign out_beat_o  = out_q;
    assign out_valid_o = out_valid_q;

endmodule

/* governor/governor_ctrl.sv */
`timescale 1ns/100ps
`include "dbg_defines.svh"

module governor_ctrl import dbg_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,

    input  logic [`DBG_CMD_WIDTH-1:0] cmd_i,
    input  logic                      cmd_valid_i,

    output logic                      rd_pause_o,
    output logic                      rd_drop_o,
    output logic                      rd_log_en_o,
    output logic                      wr_pause_o,
    output logic                      wr_drop_o,
    output logic                      wr_log_en_o,

    output rdata_beat_t               rd_inj_beat_o,
    output logic                      rd_inj_valid_o,
    input  logic                      rd_inj_ready_i,

    output wdata_beat_t               wr_inj_beat_o,
    output logic                      wr_inj_valid_o,
    input  logic                      wr_inj_ready_i,

    output logic                      done_o,
    output logic                      busy_o
);

    localparam int inj_width = `DBG_INJ_MSB - `DBG_INJ_LSB + 1;

    dbg_op_e                    op;
    dbg_chan_e                  chan;
    logic [inj_width-1:0]       inj_payload;
    logic [`DBG_DATA_WIDTH-1:0] inj_data_ext;

    // per channel, indexed by dbg_chan_e
    logic [1:0]                 pause_q;
    logic [1:0]                 drop_q;
    logic [1:0]                 log_q;
    logic [1:0]                 inj_valid_q;
    logic [1:0]                 inj_ready;
    logic [inj_width-1:0]       inj_data_q;
    logic                       done_q;

    //////////////////////////////////////////////////
    // command fields
    //////////////////////////////////////////////////

    assign op          = dbg_op_e'(cmd_i[`DBG_OP_WIDTH-1:0]);
    assign chan        = dbg_chan_e'(cmd_i[`DBG_CHAN_BIT]);
    assign inj_payload = cmd_i[`DBG_INJ_MSB:`DBG_INJ_LSB];

    assign inj_ready[CH_RDATA] = rd_inj_ready_i;
    assign inj_ready[CH_WDATA] = wr_inj_ready_i;

    //////////////////////////////////////////////////
    // setting and inject registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pause_q     <= '0;
            drop_q      <= '0;
            log_q       <= '0;
            inj_valid_q <= '0;
            done_q      <= 1'b0;
        end else begin
            done_q <= 1'b0;

            // inject completes on its handshake, done follows a cycle later
            for (int c = 0; c < 2; c++) begin
                if (inj_valid_q[c] && inj_ready[c]) begin
                    inj_valid_q[c] <= 1'b0;
                    done_q         <= 1'b1;
                end
            end

            if (cmd_valid_i) begin
                case (op)
                    OP_NOP:     ;
                    OP_PAUSE:   pause_q[chan] <= 1'b1;
                    OP_UNPAUSE: pause_q[chan] <= 1'b0;
                    OP_DROP:    drop_q[chan]  <= 1'b1;
                    OP_UNDROP:  drop_q[chan]  <= 1'b0;
                    OP_LOG:     log_q[chan]   <= 1'b1;
                    OP_UNLOG:   log_q[chan]   <= 1'b0;
                    OP_INJECT:  inj_valid_q[chan] <= 1'b1;
                    // unknown opcodes behave as nop
                    default:    ;
                endcase
                if (op != OP_INJECT) begin
                    done_q <= 1'b1;
                end
            end
        end
    end

    // payload held for the whole pending inject
    always_ff @(posedge clk) begin
        if (cmd_valid_i && op == OP_INJECT) begin
            inj_data_q <= inj_payload;
        end
    end

    assign inj_data_ext = {{(`DBG_DATA_WIDTH - inj_width){1'b0}}, inj_data_q};

    //////////////////////////////////////////////////
    // outputs
    //////////////////////////////////////////////////

    assign rd_pause_o  = pause_q[CH_RDATA];
    assign rd_drop_o   = drop_q[CH_RDATA];
    assign rd_log_en_o = log_q[CH_RDATA];
    assign wr_pause_o  = pause_q[CH_WDATA];
    assign wr_drop_o   = drop_q[CH_WDATA];
    assign wr_log_en_o = log_q[CH_WDATA];

    assign rd_inj_beat_o.data = inj_data_ext;
    assign rd_inj_beat_o.dest = '0;
    assign rd_inj_valid_o     = inj_valid_q[CH_RDATA];

    assign wr_inj_beat_o.data = inj_data_ext;
    assign wr_inj_valid_o     = inj_valid_q[CH_WDATA];

    assign done_o = done_q;
    // pending inject on either channel
    assign busy_o = |inj_valid_q;

endmodule

/* verilog/dbg_datapath.sv */
`timescale 1ns/100ps
`include "dbg_defines.svh"

module dbg_datapath import dbg_pkg::*; (
    input  logic                      clk,
    input  logic                      rst,

    input  logic [`DBG_CMD_WIDTH-1:0] cmd_i,
    input  logic                      cmd_valid_i,
    output logic                      done_o,
    output logic                      busy_o,

    // rdata, master side in, slave side out
    input  rdata_beat_t               rd_in_beat_i,
    input  logic                      rd_in_valid_i,
    output logic                      rd_in_ready_o,
    output rdata_beat_t               rd_out_beat_o,
    output logic                      rd_out_valid_o,
    input  logic                      rd_out_ready_i,
    output rdata_beat_t               rd_log_beat_o,
    output logic                      rd_log_valid_o,
    input  logic                      rd_log_ready_i,

    // wdata
    input  wdata_beat_t               wr_in_beat_i,
    input  logic                      wr_in_valid_i,
    output logic                      wr_in_ready_o,
    output wdata_beat_t               wr_out_beat_o,
    output logic                      wr_out_valid_o,
    input  logic                      wr_out_ready_i,
    output wdata_beat_t               wr_log_beat_o,
    output logic                      wr_log_valid_o,
    input  logic                      wr_log_ready_i
);

    logic        rd_pause;
    logic        rd_drop;
    logic        rd_log_en;
    logic        wr_pause;
    logic        wr_drop;
    logic        wr_log_en;

    rdata_beat_t rd_inj_beat;
    logic        rd_inj_valid;
    logic        rd_inj_ready;
    wdata_beat_t wr_inj_beat;
    logic        wr_inj_valid;
    logic        wr_inj_ready;

    //////////////////////////////////////////////////
    // command and settings
    //////////////////////////////////////////////////

    governor_ctrl u_ctrl (
        .clk            (clk),
        .rst            (rst),
        .cmd_i          (cmd_i),
        .cmd_valid_i    (cmd_valid_i),
        .rd_pause_o     (rd_pause),
        .rd_drop_o      (rd_drop),
        .rd_log_en_o    (rd_log_en),
        .wr_pause_o     (wr_pause),
        .wr_drop_o      (wr_drop),
        .wr_log_en_o    (wr_log_en),
        .rd_inj_beat_o  (rd_inj_beat),
        .rd_inj_valid_o (rd_inj_valid),
        .rd_inj_ready_i (rd_inj_ready),
        .wr_inj_beat_o  (wr_inj_beat),
        .wr_inj_valid_o (wr_inj_valid),
        .wr_inj_ready_i (wr_inj_ready),
        .done_o         (done_o),
        .busy_o         (busy_o)
    );

    //////////////////////////////////////////////////
    // one governor per channel
    //////////////////////////////////////////////////

    stream_governor #(
        .beat_t (rdata_beat_t)
    ) u_gov_rdata (
        .clk         (clk),
        .rst         (rst),
        .in_beat_i   (rd_in_beat_i),
        .in_valid_i  (rd_in_valid_i),
        .in_ready_o  (rd_in_ready_o),
        .out_beat_o  (rd_out_beat_o),
        .out_valid_o (rd_out_valid_o),
        .out_ready_i (rd_out_ready_i),
        .inj_beat_i  (rd_inj_beat),
        .inj_valid_i (rd_inj_valid),
        .inj_ready_o (rd_inj_ready),
        .log_beat_o  (rd_log_beat_o),
        .log_valid_o (rd_log_valid_o),
        .log_ready_i (rd_log_ready_i),
        .pause_i     (rd_pause),
        .drop_i      (rd_drop),
        .log_en_i    (rd_log_en)
    );

    stream_governor #(
        .beat_t (wdata_beat_t)
    ) u_gov_wdata (
        .clk         (clk),
        .rst         (rst),
        .in_beat_i   (wr_in_beat_i),
        .in_valid_i  (wr_in_valid_i),
        .in_ready_o  (wr_in_ready_o),
        .out_beat_o  (wr_out_beat_o),
        .out_valid_o (wr_out_valid_o),
        .out_ready_i (wr_out_ready_i),
        .inj_beat_i  (wr_inj_beat),
        .inj_valid_i (wr_inj_valid),
        .inj_ready_o (wr_inj_ready),
        .log_beat_o  (wr_log_beat_o),
        .log_valid_o (wr_log_valid_o),
        .log_ready_i (wr_log_ready_i),
        .pause_i     (wr_pause),
        .drop_i      (wr_drop),
        .log_en_i    (wr_log_en)
    );

endmodule

/* tests/dbg_datapath_chk.sv */
`timescale 1ns/100ps

module dbg_datapath_chk import dbg_pkg::*; (
    input logic        clk,
    input logic        rst,
    input logic        cmd_valid_i,
    input logic        done_i,
    input logic        busy_i,
    input rdata_beat_t rd_out_beat_i,
    input logic        rd_out_valid_i,
    input logic        rd_out_ready_i,
    input wdata_beat_t wr_out_beat_i,
    input logic        wr_out_valid_i,
    input logic        wr_out_ready_i,
    // settings, inject valids and log valids of both channels
    input logic [9:0]  ctrl_i
);

    int fail_count = 0;

    // a registered beat holds until the far side takes it
    a_rd_hold: assert property (@(posedge clk) disable iff (rst)
        rd_out_valid_i && !rd_out_ready_i |=> rd_out_valid_i && $stable(rd_out_beat_i))
        else begin
            $error("rdata output beat changed before it was accepted");
            fail_count++;
        end

    a_wr_hold: assert property (@(posedge clk) disable iff (rst)
        wr_out_valid_i && !wr_out_ready_i |=> wr_out_valid_i && $stable(wr_out_beat_i))
        else begin
            $error("wdata output beat changed before it was accepted");
            fail_count++;
        end

    a_done_pulse: assert property (@(posedge clk) disable iff (rst) done_i |=> !done_i)
        else begin
            $error("done_o high for more than one cycle");
            fail_count++;
        end

    a_cmd_idle: assert property (@(posedge clk) disable iff (rst) !(busy_i && cmd_valid_i))
        else begin
            $error("command strobe while busy_o is high");
            fail_count++;
        end

    a_reset_low: assert property (@(posedge clk)
        rst |=> ctrl_i == '0 && !done_i && !busy_i && !rd_out_valid_i && !wr_out_valid_i)
        else begin
            $error("control output not low after reset");
            fail_count++;
        end

endmodule

bind dbg_datapath dbg_datapath_chk u_chk (
    .clk            (clk),
    .rst            (rst),
    .cmd_valid_i    (cmd_valid_i),
    .done_i         (done_o),
    .busy_i         (busy_o),
    .rd_out_beat_i  (rd_out_beat_o),
    .rd_out_valid_i (rd_out_valid_o),
    .rd_out_ready_i (rd_out_ready_i),
    .wr_out_beat_i  (wr_out_beat_o),
    .wr_out_valid_i (wr_out_valid_o),
    .wr_out_ready_i (wr_out_ready_i),
    .ctrl_i         ({rd_pause, rd_drop, rd_log_en, wr_pause, wr_drop, wr_log_en,
                      rd_inj_valid, wr_inj_valid, rd_log_valid_o, wr_log_valid_o})
);

/* tests/tb_dbg_datapath.sv */
`timescale 1ns/100ps
`include "dbg_defines.svh"

module tb_dbg_datapath import dbg_pkg::*; ();

    localparam int num_rows      = 15;
    localparam int beats_per_row = 8;
    localparam int cycle_limit   = 4 * num_rows * beats_per_row;

    localparam logic [1:0] rdy_on   = 2'd0;
    localparam logic [1:0] rdy_rand = 2'd1;
    localparam logic [1:0] rdy_off  = 2'd2;

    // command, beats per channel, out-ready pattern, channels expected to drain
    typedef struct packed {
        dbg_op_e     op;
        dbg_chan_e   chan;
        logic [15:0] payload;
        logic [3:0]  n_rd;
        logic [3:0]  n_wr;
        logic [1:0]  mode;
        logic [1:0]  drain;
    } row_t;

    logic                      clk;
    logic                      rst;
    logic [`DBG_CMD_WIDTH-1:0] cmd;
    logic                      cmd_valid;
    logic                      done;
    logic                      busy;

    rdata_beat_t rd_in_beat;
    logic        rd_in_valid;
    logic        rd_in_ready;
    rdata_beat_t rd_out_beat;
    logic        rd_out_valid;
    logic        rd_out_ready;
    rdata_beat_t rd_log_beat;
    logic        rd_log_valid;
    logic        rd_log_ready;

    wdata_beat_t wr_in_beat;
    logic        wr_in_valid;
    logic        wr_in_ready;
    wdata_beat_t wr_out_beat;
    logic        wr_out_valid;
    logic        wr_out_ready;
    wdata_beat_t wr_log_beat;
    logic        wr_log_valid;
    logic        wr_log_ready;

    row_t        rows [num_rows];
    rdata_beat_t src_rd [$];
    rdata_beat_t exp_rd [$];
    rdata_beat_t log_rd [$];
    wdata_beat_t src_wr [$];
    wdata_beat_t exp_wr [$];
    wdata_beat_t log_wr [$];

    // settings model indexed by channel
    logic [1:0] pause_m;
    logic [1:0] drop_m;
    logic [1:0] log_m;
    logic [1:0] ready_mode;
    integer     seed = 32'he000_5c6f;
    int         cycles = 0;
    int         done_seen = 0;
    int         cmds_sent = 0;
    int         serial = 0;

    dbg_datapath u_dbg_datapath (
        .clk            (clk),
        .rst            (rst),
        .cmd_i          (cmd),
        .cmd_valid_i    (cmd_valid),
        .done_o         (done),
        .busy_o         (busy),
        .rd_in_beat_i   (rd_in_beat),
        .rd_in_valid_i  (rd_in_valid),
        .rd_in_ready_o  (rd_in_ready),
        .rd_out_beat_o  (rd_out_beat),
        .rd_out_valid_o (rd_out_valid),
        .rd_out_ready_i (rd_out_ready),
        .rd_log_beat_o  (rd_log_beat),
        .rd_log_valid_o (rd_log_valid),
        .rd_log_ready_i (rd_log_ready),
        .wr_in_beat_i   (wr_in_beat),
        .wr_in_valid_i  (wr_in_valid),
        .wr_in_ready_o  (wr_in_ready),
        .wr_out_beat_o  (wr_out_beat),
        .wr_out_valid_o (wr_out_valid),
        .wr_out_ready_i (wr_out_ready),
        .wr_log_beat_o  (wr_log_beat),
        .wr_log_valid_o (wr_log_valid),
        .wr_log_ready_i (wr_log_ready)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic report_error(input string msg);
        $display("error at %0t ns: %s", $time, msg);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    function automatic logic [`DBG_CMD_WIDTH-1:0] make_cmd(input dbg_op_e op,
                                                          input dbg_chan_e ch,
                                                          input logic [15:0] payload);
        logic [`DBG_CMD_WIDTH-1:0] w;
        w = '0;
        w[`DBG_OP_WIDTH-1:0] = op;
        w[`DBG_CHAN_BIT] = ch;
        w[`DBG_INJ_MSB:`DBG_INJ_LSB] = payload;
        return w;
    endfunction

    function automatic rdata_beat_t make_rd_beat(input int n);
        rdata_beat_t b;
        b.data = {32'(n) * 32'h9e37_79b9, 32'h0d00_0000 + 32'(n)};
        b.dest = 16'(n) ^ 16'h5a5a;
        return b;
    endfunction

    function automatic wdata_beat_t make_wr_beat(input int n);
        wdata_beat_t b;
        b.data = {32'h7700_0000 | 32'(n), ~(32'(n) * 32'h9e37_79b9)};
        return b;
    endfunction

    // strobe one command, then wait for its done pulse
    task automatic issue_cmd(input dbg_op_e op, input dbg_chan_e ch, input logic [15:0] payload);
        rdata_beat_t ib_rd;
        wdata_beat_t ib_wr;
        assert (!busy) else report_error("busy_o high before a command");
        if (op == OP_INJECT) begin
            ib_rd.data = 64'(payload);
            ib_rd.dest = '0;
            ib_wr.data = 64'(payload);
            if (ch == CH_RDATA) exp_rd.push_back(ib_rd);
            else exp_wr.push_back(ib_wr);
        end
        cmd = make_cmd(op, ch, payload);
        cmd_valid = 1'b1;
        @(negedge clk);
        cmd_valid = 1'b0;
        cmds_sent++;
        case (op)
            OP_PAUSE:   pause_m[ch] = 1'b1;
            OP_UNPAUSE: pause_m[ch] = 1'b0;
            OP_DROP:    drop_m[ch] = 1'b1;
            OP_UNDROP:  drop_m[ch] = 1'b0;
            OP_LOG:     log_m[ch] = 1'b1;
            OP_UNLOG:   log_m[ch] = 1'b0;
            default:    ;
        endcase
        if (op == OP_INJECT) begin
            assert (busy) else report_error("busy_o low after an inject strobe");
            while (!done) @(negedge clk);
            assert (!busy) else report_error("busy_o still high at inject done");
        end else begin
            assert (done) else report_error("no done_o one cycle after the command");
        end
        @(negedge clk);
        assert (!done) else report_error("done_o high for more than one cycle");
    endtask

    // wait for the chosen channels to empty, then check that the others stalled
    task automatic wait_drained(input logic [1:0] mask);
        while ((mask[0] && (src_rd.size() + exp_rd.size() + log_rd.size() > 0)) ||
               (mask[1] && (src_wr.size() + exp_wr.size() + log_wr.size() > 0))) begin
            @(negedge clk);
        end
        if (mask != 2'b11) begin
            repeat (4) @(negedge clk);
            assert (mask[0] || (!rd_out_valid && !rd_in_ready && src_rd.size() > 0))
                else report_error("paused rdata channel did not stall");
            assert (mask[1] || (!wr_out_valid && !wr_in_ready && src_wr.size() > 0))
                else report_error("paused wdata channel did not stall");
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus and scoreboard
    //////////////////////////////////////////////////

    // ready patterns and source beats change on the falling edge
    always @(negedge clk) begin : drive_streams
        logic [3:0] coin;
        coin = 4'($random(seed));
        rd_out_ready = (ready_mode == rdy_on) || (ready_mode == rdy_rand && coin[0]);
        wr_out_ready = (ready_mode == rdy_on) || (ready_mode == rdy_rand && coin[1]);
        rd_log_ready = coin[2];
        wr_log_ready = coin[3];
        rd_in_valid = src_rd.size() > 0;
        if (src_rd.size() > 0) rd_in_beat = src_rd[0];
        wr_in_valid = src_wr.size() > 0;
        if (src_wr.size() > 0) wr_in_beat = src_wr[0];
    end

    // handshakes sampled before the edge updates the DUT registers
    always @(posedge clk) begin
        cycles++;
        assert (cycles < cycle_limit) else begin
            $display("timeout: stimulus table not finished within %0d cycles", cycle_limit);
            $display("RESULT: FAIL");
            $fatal(1, "timeout");
        end
        assert (u_dbg_datapath.u_chk.fail_count == 0)
            else report_error("bound checker flagged a protocol violation");
        if (!rst) begin
            if (done) done_seen++;
            if (rd_in_valid && rd_in_ready) begin
                assert (!pause_m[CH_RDATA]) else report_error("rdata beat taken while paused");
                void'(src_rd.pop_front());
                if (!drop_m[CH_RDATA]) exp_rd.push_back(rd_in_beat);
                if (log_m[CH_RDATA]) log_rd.push_back(rd_in_beat);
            end
            if (wr_in_valid && wr_in_ready) begin
                assert (!pause_m[CH_WDATA]) else report_error("wdata beat taken while paused");
                void'(src_wr.pop_front());
                if (!drop_m[CH_WDATA]) exp_wr.push_back(wr_in_beat);
                if (log_m[CH_WDATA]) log_wr.push_back(wr_in_beat);
            end
            if (rd_out_valid && rd_out_ready) begin
                assert (exp_rd.size() > 0) else report_error("rdata output beat not expected");
                assert (rd_out_beat == exp_rd[0]) else report_error(
                    $sformatf("rdata out %h, expected %h", rd_out_beat, exp_rd[0]));
                void'(exp_rd.pop_front());
            end
            if (wr_out_valid && wr_out_ready) begin
                assert (exp_wr.size() > 0) else report_error("wdata output beat not expected");
                assert (wr_out_beat == exp_wr[0]) else report_error(
                    $sformatf("wdata out %h, expected %h", wr_out_beat, exp_wr[0]));
                void'(exp_wr.pop_front());
            end
            assert (log_m[CH_RDATA] || !rd_log_valid) else report_error("rdata log valid, log off");
            assert (log_m[CH_WDATA] || !wr_log_valid) else report_error("wdata log valid, log off");
            if (rd_log_valid && rd_log_ready) begin
                assert (log_rd.size() > 0 && rd_log_beat == log_rd[0])
                    else report_error($sformatf("rdata log beat %h unexpected", rd_log_beat));
                void'(log_rd.pop_front());
            end
            if (wr_log_valid && wr_log_ready) begin
                assert (log_wr.size() > 0 && wr_log_beat == log_wr[0])
                    else report_error($sformatf("wdata log beat %h unexpected", wr_log_beat));
                void'(log_wr.pop_front());
            end
        end
    end

    initial begin
        rst = 1'b1;
        cmd = '0;
        cmd_valid = 1'b0;
        rd_in_beat = '0;
        rd_in_valid = 1'b0;
        rd_out_ready = 1'b0;
        rd_log_ready = 1'b0;
        wr_in_beat = '0;
        wr_in_valid = 1'b0;
        wr_out_ready = 1'b0;
        wr_log_ready = 1'b0;
        pause_m = '0;
        drop_m = '0;
        log_m = '0;
        ready_mode = rdy_on;

        // op, channel, payload, rd beats, wr beats, ready, drain mask {wr, rd}
        rows[0]  = '{OP_NOP,     CH_RDATA, 16'h0000, 4'd6, 4'd6, rdy_rand, 2'b11};
        rows[1]  = '{OP_PAUSE,   CH_RDATA, 16'h0000, 4'd3, 4'd6, rdy_rand, 2'b10};
        rows[2]  = '{OP_UNPAUSE, CH_RDATA, 16'h0000, 4'd0, 4'd0, rdy_rand, 2'b11};
        rows[3]  = '{OP_PAUSE,   CH_WDATA, 16'h0000, 4'd6, 4'd2, rdy_rand, 2'b01};
        rows[4]  = '{OP_UNPAUSE, CH_WDATA, 16'h0000, 4'd0, 4'd0, rdy_rand, 2'b11};
        rows[5]  = '{OP_DROP,    CH_RDATA, 16'h0000, 4'd6, 4'd0, rdy_off,  2'b11};
        rows[6]  = '{OP_UNDROP,  CH_RDATA, 16'h0000, 4'd4, 4'd4, rdy_rand, 2'b11};
        rows[7]  = '{OP_DROP,    CH_WDATA, 16'h0000, 4'd0, 4'd6, rdy_off,  2'b11};
        rows[8]  = '{OP_UNDROP,  CH_WDATA, 16'h0000, 4'd4, 4'd4, rdy_rand, 2'b11};
        rows[9]  = '{OP_LOG,     CH_RDATA, 16'h0000, 4'd6, 4'd6, rdy_rand, 2'b11};
        rows[10] = '{OP_LOG,     CH_WDATA, 16'h0000, 4'd6, 4'd6, rdy_rand, 2'b11};
        rows[11] = '{OP_UNLOG,   CH_RDATA, 16'h0000, 4'd4, 4'd4, rdy_on,   2'b11};
        rows[12] = '{OP_UNLOG,   CH_WDATA, 16'h0000, 4'd4, 4'd4, rdy_rand, 2'b11};
        rows[13] = '{OP_INJECT,  CH_RDATA, 16'hbeef, 4'd4, 4'd4, rdy_rand, 2'b11};
        rows[14] = '{OP_INJECT,  CH_WDATA, 16'h5a3c, 4'd4, 4'd4, rdy_rand, 2'b11};

        repeat (4) @(negedge clk);
        rst = 1'b0;

        for (int r = 0; r < num_rows; r++) begin
            ready_mode = rows[r].mode;
            issue_cmd(rows[r].op, rows[r].chan, rows[r].payload);
            // beats offered only after done, so an inject leads them
            for (int b = 0; b < rows[r].n_rd; b++) begin
                src_rd.push_back(make_rd_beat(serial));
                serial++;
            end
            for (int b = 0; b < rows[r].n_wr; b++) begin
                src_wr.push_back(make_wr_beat(serial));
                serial++;
            end
            wait_drained(rows[r].drain);
        end

        if (done_seen == cmds_sent && u_dbg_datapath.u_chk.fail_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("done pulses %0d for %0d commands, or a checker assertion failed",
                     done_seen, cmds_sent);
            $display("RESULT: FAIL");
            $fatal(1, "final check failed");
        end
    end

endmodule

/* list.f */
+incdir+common
common/dbg_pkg.sv
governor/stream_governor.sv
governor/governor_ctrl.sv
verilog/dbg_datapath.sv
tests/dbg_datapath_chk.sv
tests/tb_dbg_datapath.sv

/* Bender.yml */
package:
  name: dbg_datapath

export_include_dirs:
  - common

sources:
  - files:
      - common/dbg_pkg.sv
      - governor/stream_governor.sv
      - governor/governor_ctrl.sv
      - verilog/dbg_datapath.sv
  - target: test
    include_dirs:
      - common
    files:
      - tests/dbg_datapath_chk.sv
      - tests/tb_dbg_datapath.sv
